//--- compile.f
logic/cart_pkg.sv
logic/rom_write_if.sv
logic/rom_read_if.sv
logic/ce_gen.sv
logic/cart_loader.sv
logic/rom_reader.sv
logic/rom_arbiter.sv
logic/cheat_code_latch.sv
logic/cart_top.sv
test/cart_sva.sv
test/cart_top_tb.sv

//--- logic/cart_loader.sv
// Cartridge download handling, write counter, mirror masks, header and Game Gear flags
`default_nettype none
`timescale 1ns/1ps

module cart_loader (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire                 ioctl_download,
	input  wire  [7:0]          ioctl_index,
	input  wire                 ioctl_wr,
	input  cart_pkg::rom_addr_t ioctl_addr,
	input  cart_pkg::rom_byte_t ioctl_dout,
	output logic                ioctl_wait,
	output logic                gg,
	output cart_pkg::rom_addr_t mask,
	output cart_pkg::rom_addr_t mask_hdr,
	output logic                hdr_present,
	rom_write_if.loader         wr
);

	logic                cart_dl;
	logic                dl_q;   // Download level, one cycle late
	cart_pkg::rom_addr_t wr_cnt; // Bytes stored so far

	assign cart_dl    = ioctl_download && (ioctl_index != cart_pkg::CODE_INDEX);
	assign wr.wr_addr = wr_cnt;

	// ==================================================
	// Write handshake
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_q        <= 1'b0;
			ioctl_wait  <= 1'b0;
			wr.wr_req   <= 1'b0;
			wr_cnt      <= '0;
			hdr_present <= 1'b0;
		end else begin
			dl_q <= cart_dl;
			if (cart_dl && !dl_q) begin
				wr_cnt <= '0;
			end else if (ioctl_wr && cart_dl) begin
				ioctl_wait <= 1'b1;
				wr.wr_req  <= ~wr.wr_req;
			end else if (ioctl_wait && (wr.wr_req == wr.wr_ack)) begin
				ioctl_wait <= 1'b0; // Byte is in the store
				wr_cnt     <= wr_cnt + 1'b1;
			end
			// Header present when the size is an odd multiple of 512
			if (dl_q && !cart_dl)
				hdr_present <= wr_cnt[$clog2(cart_pkg::HEADER_BYTES)];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && cart_dl)
			wr.wr_data <= ioctl_dout;
	end

	// ==================================================
	// Mirror masks and console type
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mask     <= '0;
			mask_hdr <= '0;
			gg       <= 1'b0;
		end else if (ioctl_wr && cart_dl) begin
			mask <= (ioctl_addr == '0) ? '0 : (mask | ioctl_addr);
			if (ioctl_addr == cart_pkg::rom_addr_t'(cart_pkg::HEADER_BYTES))
				mask_hdr <= '0; // First byte past the header
			else
				mask_hdr <= mask_hdr |
					(ioctl_addr - cart_pkg::rom_addr_t'(cart_pkg::HEADER_BYTES));
			gg <= (ioctl_index[4:0] == cart_pkg::GG_INDEX);
		end
	end

endmodule

`default_nettype wire

//--- logic/cart_pkg.sv
// Shared widths, download indices, ROM address and data types, cheat code record type
`default_nettype none

package cart_pkg;

	// ==================================================
	// Sizes
	// ==================================================
	localparam int ROM_ADDR_W   = 14;  // ROM store and console address
	localparam int HEADER_BYTES = 512; // Optional image header
	localparam int CE_PERIOD    = 30;  // Enable pattern length
	localparam int CODE_BYTES   = 16;  // Bytes per cheat record
	localparam int CODE_W       = 128;

	// Download indices
	localparam logic [7:0] CODE_INDEX = 8'hFF;
	localparam logic [4:0] GG_INDEX   = 5'd2; // Low five index bits

	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [7:0]            rom_byte_t;

	// Field order from the top, as the cheat engine expects
	typedef struct packed {
		logic [CODE_W/4-1:0] flags;
		logic [CODE_W/4-1:0] address;
		logic [CODE_W/4-1:0] compare;
		logic [CODE_W/4-1:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

//--- logic/cart_top.sv
// Cartridge side top level with enable generator, loader, reader, arbiter and cheat latch
`default_nettype none
`timescale 1ns/1ps

module cart_top (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	// Host download stream
	input  wire                   ioctl_download,
	input  wire  [7:0]            ioctl_index,
	input  wire                   ioctl_wr,
	input  cart_pkg::rom_addr_t   ioctl_addr,
	input  cart_pkg::rom_byte_t   ioctl_dout,
	output logic                  ioctl_wait,
	// Console ROM port
	input  wire                   rom_rd,
	input  cart_pkg::rom_addr_t   rom_a,
	output cart_pkg::rom_byte_t   rom_do,
	output logic                  rom_rdy,
	output logic                  gg,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid,
	// Enables
	output logic                  ce_cpu,
	output logic                  ce_vdp,
	output logic                  ce_pix,
	output logic                  ce_sp
);

	cart_pkg::rom_addr_t mask;
	cart_pkg::rom_addr_t mask_hdr;
	logic                hdr_present;

	rom_write_if wr_bus ();
	rom_read_if  rd_bus ();

	ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader u_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.gg             (gg),
		.mask           (mask),
		.mask_hdr       (mask_hdr),
		.hdr_present    (hdr_present),
		.wr             (wr_bus.loader)
	);

	rom_reader u_reader (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rom_rd      (rom_rd),
		.rom_a       (rom_a),
		.mask        (mask),
		.mask_hdr    (mask_hdr),
		.hdr_present (hdr_present),
		.rom_do      (rom_do),
		.rom_rdy     (rom_rdy),
		.rd          (rd_bus.reader)
	);

	rom_arbiter u_arbiter (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr      (wr_bus.arbiter),
		.rd      (rd_bus.arbiter)
	);

	cheat_code_latch u_cheat (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.code           (code),
		.code_valid     (code_valid)
	);

endmodule

`default_nettype wire

//--- logic/ce_gen.sv
// Clock enable generator for cpu, vdp, pixel and sound strobes
`default_nettype none
`timescale 1ns/1ps

module ce_gen (
	input  wire  clk_sys,
	input  wire  rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	logic [$clog2(cart_pkg::CE_PERIOD)-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (int'(cnt) == cart_pkg::CE_PERIOD - 1)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			ce_sp  <= cnt[0]; // Half rate
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;

			// Fixed phase plan, cpu offset from pixel at 24
			case (int'(cnt))
				4, 14: ce_vdp <= 1'b1;
				9: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
					ce_cpu <= 1'b1;
				end
				19, 29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				24: begin
					ce_vdp <= 1'b1;
					ce_cpu <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/cheat_code_latch.sv
// Cheat record assembly from the download stream into one code word
`default_nettype none
`timescale 1ns/1ps

module cheat_code_latch (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	input  wire                   ioctl_download,
	input  wire  [7:0]            ioctl_index,
	input  wire                   ioctl_wr,
	input  cart_pkg::rom_addr_t   ioctl_addr,
	input  cart_pkg::rom_byte_t   ioctl_dout,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid
);

	logic       code_wr;
	logic [3:0] rec_off; // Byte within the record

	assign code_wr = ioctl_download && (ioctl_index == cart_pkg::CODE_INDEX) && ioctl_wr;
	assign rec_off = ioctl_addr[3:0];

	// Four bytes per field, low byte first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (rec_off[3:2])
				2'd0: code.flags[{rec_off[1:0], 3'b000} +: 8]   <= ioctl_dout;
				2'd1: code.address[{rec_off[1:0], 3'b000} +: 8] <= ioctl_dout;
				2'd2: code.compare[{rec_off[1:0], 3'b000} +: 8] <= ioctl_dout;
				default: code.replace[{rec_off[1:0], 3'b000} +: 8] <= ioctl_dout;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (int'(rec_off) == cart_pkg::CODE_BYTES - 1);
	end

endmodule

`default_nettype wire

//--- logic/rom_arbiter.sv
// ROM store with read-first arbitration between loader writes and console reads
`default_nettype none
`timescale 1ns/1ps

module rom_arbiter (
	input  wire          clk_sys,
	input  wire          rst_n,
	rom_write_if.arbiter wr,
	rom_read_if.arbiter  rd
);

	// ==================================================
	// Store
	// ==================================================
	cart_pkg::rom_byte_t mem [2**cart_pkg::ROM_ADDR_W];

	logic wr_pending;
	logic wr_grant;

	assign wr_pending = (wr.wr_req != wr.wr_ack);
	assign wr_grant   = wr_pending && !rd.rd; // Reads never wait

	always_ff @(posedge clk_sys) begin
		if (rd.rd)
			rd.rd_data <= mem[rd.rd_addr];
		if (wr_grant)
			mem[wr.wr_addr] <= wr.wr_data;
	end

	// ==================================================
	// Control
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd.rd_valid <= 1'b0;
			wr.wr_ack   <= 1'b0;
		end else begin
			rd.rd_valid <= rd.rd;
			if (wr_grant)
				wr.wr_ack <= wr.wr_req; // Same cycle as the store
		end
	end

endmodule

`default_nettype wire

//--- logic/rom_read_if.sv
// Reader to arbiter read channel with request pulse and returned data
`default_nettype none
`timescale 1ns/1ps

interface rom_read_if;

	logic                rd;       // One-cycle request
	cart_pkg::rom_addr_t rd_addr;  // Already mirrored
	cart_pkg::rom_byte_t rd_data;
	logic                rd_valid; // Cycle after rd

	modport reader (
		output rd, rd_addr,
		input  rd_data, rd_valid
	);

	modport arbiter (
		input  rd, rd_addr,
		output rd_data, rd_valid
	);

endinterface

`default_nettype wire

//--- logic/rom_reader.sv
// Console ROM address mirroring with header skip and read request issue
`default_nettype none
`timescale 1ns/1ps

module rom_reader (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire                 rom_rd,
	input  cart_pkg::rom_addr_t rom_a,
	input  cart_pkg::rom_addr_t mask,
	input  cart_pkg::rom_addr_t mask_hdr,
	input  wire                 hdr_present,
	output cart_pkg::rom_byte_t rom_do,
	output logic                rom_rdy,
	rom_read_if.reader          rd
);

	cart_pkg::rom_addr_t map_addr;

	// Skip the header, then fold into the image size
	always_comb begin
		if (hdr_present)
			map_addr = (rom_a + cart_pkg::rom_addr_t'(cart_pkg::HEADER_BYTES)) & mask_hdr;
		else
			map_addr = rom_a & mask;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rd.rd <= 1'b0;
		else
			rd.rd <= rom_rd;
	end

	always_ff @(posedge clk_sys) begin
		rd.rd_addr <= map_addr;
	end

	// Data returns one cycle after the request
	assign rom_do  = rd.rd_data;
	assign rom_rdy = rd.rd_valid;

endmodule

`default_nettype wire

//--- logic/rom_write_if.sv
// Loader to arbiter write channel with toggle request and acknowledge
`default_nettype none
`timescale 1ns/1ps

interface rom_write_if;

	logic                wr_req;  // Toggles once per byte
	cart_pkg::rom_addr_t wr_addr;
	cart_pkg::rom_byte_t wr_data;
	logic                wr_ack;  // Follows wr_req when stored

	modport loader (
		output wr_req, wr_addr, wr_data,
		input  wr_ack
	);

	modport arbiter (
		input  wr_req, wr_addr, wr_data,
		output wr_ack
	);

endinterface

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cartridge testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cart_top_tb -f compile.f -o cart_sim \
	|| { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/cart_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "RESULT: PASS" \
	&& exit 0 \
	|| { echo "Simulation did not pass"; exit 1; }

//--- test/cart_sva.sv
// Bound assertions for read latency, enable overlap and download handshake
`default_nettype none
`timescale 1ns/1ps

module cart_sva (
	input wire clk_sys,
	input wire rst_n,
	input wire rom_rd,
	input wire rom_rdy,
	input wire ce_cpu,
	input wire ce_vdp,
	input wire ioctl_wr,
	input wire ioctl_wait
);

	localparam int WAIT_LIMIT = 16; // Two reads in a row at most ahead of a write

	int unsigned wait_cycles;

	always_ff @(posedge clk_sys) begin
		if (!rst_n || !ioctl_wait)
			wait_cycles <= 0;
		else
			wait_cycles <= wait_cycles + 1;
	end

	// ==================================================
	// Properties
	// ==================================================
	rdy_two_after_rd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_rdy == $past(rom_rd, 2))
		else $error("rom_rdy does not follow rom_rd by two cycles");

	cpu_with_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_cpu |-> ce_vdp)
		else $error("ce_cpu pulse without ce_vdp");

	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(ioctl_wr && ioctl_wait))
		else $error("ioctl_wr pulsed while ioctl_wait is high");

	wait_falls: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wait_cycles < WAIT_LIMIT)
		else $error("ioctl_wait stuck high");

endmodule

bind cart_top cart_sva u_sva (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.rom_rd     (rom_rd),
	.rom_rdy    (rom_rdy),
	.ce_cpu     (ce_cpu),
	.ce_vdp     (ce_vdp),
	.ioctl_wr   (ioctl_wr),
	.ioctl_wait (ioctl_wait)
);

`default_nettype wire

//--- test/cart_top_tb.sv
// Testbench for cart_top with enable pattern, image downloads, mirrored reads and cheat record
`default_nettype none
`timescale 1ns/1ps

module cart_top_tb;

	localparam int N_READS      = 14;
	localparam int LOAD_BYTES   = 4096 * 2 + 1536 + 16 * 3;
	localparam int LIMIT_CYCLES = 4 + 60 + LOAD_BYTES * 12 + N_READS * 4 + 500;

	typedef struct packed {
		logic                hdr;  // Entry belongs to the header image
		cart_pkg::rom_addr_t addr;
	} read_entry_t;

	logic                  clk_sys = 1'b0;
	logic                  rst_n;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wr;
	cart_pkg::rom_addr_t   ioctl_addr;
	cart_pkg::rom_byte_t   ioctl_dout;
	logic                  ioctl_wait;
	logic                  rom_rd;
	cart_pkg::rom_addr_t   rom_a;
	cart_pkg::rom_byte_t   rom_do;
	logic                  rom_rdy;
	logic                  gg;
	cart_pkg::cheat_code_t code;
	logic                  code_valid;
	logic                  ce_cpu;
	logic                  ce_vdp;
	logic                  ce_pix;
	logic                  ce_sp;

	// Model of the last image and the masks it leaves behind
	cart_pkg::rom_byte_t img [2**cart_pkg::ROM_ADDR_W];
	cart_pkg::rom_addr_t m_mask     = '0;
	cart_pkg::rom_addr_t m_mask_hdr = '0;
	logic                m_hdr_present = 1'b0;

	logic [31:0] lfsr_state = 32'h863effe3;
	int          errors = 0;
	int          checks = 0;
	int          n_done;      // Bytes acknowledged so far
	logic        dl_active;
	int          valid_pulses = 0;

	read_entry_t read_table [N_READS] = '{
		'{1'b0, 14'h0000}, '{1'b0, 14'h0001}, '{1'b0, 14'h07FF}, '{1'b0, 14'h0FFF},
		'{1'b0, 14'h1000}, '{1'b0, 14'h1ABC}, '{1'b0, 14'h2FFF}, '{1'b0, 14'h3FFF},
		'{1'b1, 14'h0000}, '{1'b1, 14'h01FF}, '{1'b1, 14'h0200}, '{1'b1, 14'h03FF},
		'{1'b1, 14'h0400}, '{1'b1, 14'h2345}
	};

	cart_top UUT (.*);

	always #10 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		if (code_valid)
			valid_pulses++;
	end

	initial begin
		#(LIMIT_CYCLES * 20);
		$display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          b;
		v = '0;
		for (b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic cart_pkg::rom_byte_t expect_byte(input cart_pkg::rom_addr_t a);
		cart_pkg::rom_addr_t m;
		if (m_hdr_present)
			m = (a + cart_pkg::rom_addr_t'(cart_pkg::HEADER_BYTES)) & m_mask_hdr;
		else
			m = a & m_mask;
		return img[m];
	endfunction

	task automatic check_val(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_enables();
		int i;
		int c;
		int n_cpu;
		int n_vdp;
		int n_pix;
		int n_sp;
		n_cpu = 0;
		n_vdp = 0;
		n_pix = 0;
		n_sp  = 0;
		for (i = 0; i < 2 * cart_pkg::CE_PERIOD; i++) begin
			@(negedge clk_sys);
			c = i % cart_pkg::CE_PERIOD;  // Count seen by the posedge just past
			check_val("ce_vdp", ce_vdp, (c % 5) == 4);
			check_val("ce_pix", ce_pix, (c % 10) == 9);
			check_val("ce_cpu", ce_cpu, (c == 9) || (c == 24));
			check_val("ce_sp", ce_sp, c[0]);
			n_cpu += int'(ce_cpu);
			n_vdp += int'(ce_vdp);
			n_pix += int'(ce_pix);
			n_sp  += int'(ce_sp);
		end
		check_val("ce_cpu count", n_cpu, 4);
		check_val("ce_vdp count", n_vdp, 12);
		check_val("ce_pix count", n_pix, 6);
		check_val("ce_sp count", n_sp, 30);
	endtask

	// ==================================================
	// Download and reads
	// ==================================================
	task automatic download(input logic [7:0] index, input int len);
		int                  k;
		cart_pkg::rom_addr_t a;
		for (k = 0; k < len; k++) begin
			a      = cart_pkg::rom_addr_t'(k);
			img[k] = cart_pkg::rom_byte_t'(take_bits(8));
			m_mask = (k == 0) ? '0 : (m_mask | a);
			if (k == cart_pkg::HEADER_BYTES)
				m_mask_hdr = '0;
			else
				m_mask_hdr = m_mask_hdr | (a - cart_pkg::rom_addr_t'(cart_pkg::HEADER_BYTES));
		end
		m_hdr_present = len[$clog2(cart_pkg::HEADER_BYTES)];
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys); // Start edge clears the write counter
		for (k = 0; k < len; k++) begin
			ioctl_wr   = 1'b1;
			ioctl_addr = cart_pkg::rom_addr_t'(k);
			ioctl_dout = img[k];
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_val("ioctl_wait", ioctl_wait, 1'b1);
			while (ioctl_wait)
				@(negedge clk_sys);
			n_done = k + 1;
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys); // Header flag settles
	endtask

	task automatic read_check(input cart_pkg::rom_addr_t a);
		cart_pkg::rom_byte_t exp;
		exp = expect_byte(a);
		@(negedge clk_sys);
		rom_rd = 1'b1;
		rom_a  = a;
		@(negedge clk_sys);
		rom_rd = 1'b0;
		check_val("rom_rdy", rom_rdy, 1'b0);
		@(negedge clk_sys);
		check_val("rom_rdy", rom_rdy, 1'b1);
		check_val("rom_do", rom_do, exp);
	endtask

	task automatic apply_table(input logic hdr_sel);
		int i;
		for (i = 0; i < N_READS; i++) begin
			if (read_table[i].hdr == hdr_sel)
				read_check(read_table[i].addr);
		end
	endtask

	// Two reads then a gap, so writes still find a free cycle
	task automatic reads_during_download();
		logic                v0;
		logic                v1;
		cart_pkg::rom_byte_t d0;
		cart_pkg::rom_byte_t d1;
		cart_pkg::rom_addr_t a;
		int                  i;
		v0 = 1'b0;
		v1 = 1'b0;
		d0 = '0;
		d1 = '0;
		i  = 0;
		while (dl_active || v0 || v1) begin
			@(negedge clk_sys);
			if (v1) begin
				check_val("rom_rdy", rom_rdy, 1'b1);
				check_val("rom_do", rom_do, d1);
			end
			v1 = v0;
			d1 = d0;
			if (dl_active && (n_done > 0) && ((i % 3) != 2)) begin
				a      = cart_pkg::rom_addr_t'(take_bits(14) % n_done); // Already stored
				rom_rd = 1'b1;
				rom_a  = a;
				v0     = 1'b1;
				d0     = expect_byte(a);
			end else begin
				rom_rd = 1'b0;
				v0     = 1'b0;
			end
			i++;
		end
	endtask

	task automatic load_cheat();
		cart_pkg::rom_byte_t   rec [cart_pkg::CODE_BYTES];
		cart_pkg::cheat_code_t exp;
		int                    k;
		for (k = 0; k < cart_pkg::CODE_BYTES; k++)
			rec[k] = cart_pkg::rom_byte_t'(take_bits(8));
		exp.flags   = {rec[3], rec[2], rec[1], rec[0]};
		exp.address = {rec[7], rec[6], rec[5], rec[4]};
		exp.compare = {rec[11], rec[10], rec[9], rec[8]};
		exp.replace = {rec[15], rec[14], rec[13], rec[12]};
		valid_pulses = 0;
		@(negedge clk_sys);
		ioctl_index    = cart_pkg::CODE_INDEX;
		ioctl_download = 1'b1;
		for (k = 0; k < cart_pkg::CODE_BYTES; k++) begin
			@(negedge clk_sys);
			ioctl_wr   = 1'b1;
			ioctl_addr = cart_pkg::rom_addr_t'(k);
			ioctl_dout = rec[k];
		end
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_val("code_valid", code_valid, 1'b1); // Cycle after byte 15
		repeat (3) @(negedge clk_sys);
		ioctl_download = 1'b0;
		check_val("code", code, exp);
		check_val("code_valid pulses", valid_pulses, 1);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd         = 1'b0;
		rom_a          = '0;
		n_done         = 0;
		dl_active      = 1'b0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		check_val("ioctl_wait", ioctl_wait, 1'b0);
		check_val("rom_rdy", rom_rdy, 1'b0);
		check_val("code_valid", code_valid, 1'b0);

		check_enables();

		download(8'h00, 4096); // Plain image
		check_val("gg", gg, 1'b0);
		apply_table(1'b0);

		n_done    = 0;
		dl_active = 1'b1;
		fork
			begin
				download(8'h00, 4096);
				dl_active = 1'b0;
			end
			reads_during_download();
		join
		apply_table(1'b0); // New image fully stored

		download(8'h00, 1536); // 512-byte header in front
		apply_table(1'b1);

		download(8'h02, 16);
		check_val("gg", gg, 1'b1);
		download(8'h01, 16);
		check_val("gg", gg, 1'b0);

		load_cheat();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
